//--- tb.f
verilog/bpu_cfg_pkg.sv
verilog/rv_inst_pkg.sv
verilog/bpu_update_if.sv
verilog/tage_direction.sv
verilog/branch_target_buffer.sv
verilog/next_pc_select.sv
verilog/bpu_top.sv
tests/bpu_asserts.sv
tests/bpu_tb.sv

//--- tests/bpu_tb.sv
module bpu_tb;
    import bpu_cfg_pkg::*;
    import rv_inst_pkg::*;

    localparam int MAX_CYCLES = 400;   // reset plus about 150 cycles of tests

    localparam xlen_t PC_BR  = 32'h0001_2040;  // plain bimodal branch
    localparam xlen_t PC_JAL = 32'h0002_0100;
    localparam xlen_t PC_HIS = 32'h0004_4200;
    localparam xlen_t PC_ALC = 32'h0000_5080;  // T1 allocation target
    localparam xlen_t PC_S0  = 32'h0001_0300;  // S0..S2 share BTB set 0xc0
    localparam xlen_t PC_S1  = 32'h0001_1300;
    localparam xlen_t PC_S2  = 32'h0001_2300;

    logic      clk;
    logic      rst;
    xlen_t     if_pc, if_inst, ex_pc, ex_target, pred_pc;
    logic      ex_valid, ex_taken, ex_pred_correct, is_cti, pred_taken;
    ghist_t    ex_history, history, exp_hist;
    provider_e ex_provider, provider;
    int        cycles = 0;

    bpu_top bpu_top_i (
        .clk(clk), .rst(rst), .if_pc_i(if_pc), .if_inst_i(if_inst),
        .ex_valid_i(ex_valid), .ex_taken_i(ex_taken), .ex_pred_correct_i(ex_pred_correct),
        .ex_pc_i(ex_pc), .ex_target_i(ex_target), .ex_history_i(ex_history),
        .ex_provider_i(ex_provider), .is_cti_o(is_cti), .pred_taken_o(pred_taken),
        .pred_pc_o(pred_pc), .provider_o(provider), .history_o(history)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (bpu_top_i.bpu_asserts_i.violations != 0) begin
            $display("a bound assertion failed");
            end_in_failure();
        end else if (cycles == MAX_CYCLES) begin
            $display("timeout: tests still running after %0d cycles", MAX_CYCLES);
            end_in_failure();
        end
    end

    task automatic end_in_failure();
        $display("*** FAILED ***");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL at %0t: %s = %h, expected %h", $time, what, got, exp);
            end_in_failure();
        end
    endtask

    // encoders for positive offsets
    function automatic xlen_t enc_jal(logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], 5'd1, OPC_JAL};
    endfunction

    function automatic xlen_t enc_branch(logic [12:0] off);
        return {off[12], off[10:5], 5'd2, 5'd1, 3'b000, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic tage_tag_t t0_tag_calc(xlen_t pc, ghist_t h);
        return pc[17:8] ^ h[15:6];
    endfunction

    function automatic tage_tag_t t1_tag_calc(xlen_t pc, ghist_t h);
        return pc[17:8] ^ {2'b00, h[7:0]};
    endfunction

    function automatic tage_idx_t t1_index_calc(xlen_t pc, ghist_t h);
        return pc[7:0] ^ h[15:8];
    endfunction

    // provider while every stored tag is still zero
    function automatic provider_e provider_with_reset_tags(xlen_t pc, ghist_t h);
        tage_tag_t t0, t1;
        t0 = t0_tag_calc(pc, h);
        t1 = t1_tag_calc(pc, h);
        if (t1[TAG_W-1 -: PARTIAL_TAG_BITS] == '0) return PROV_T1;
        if (t0[TAG_W-1 -: PARTIAL_TAG_BITS] == '0) return PROV_T0;
        return PROV_BIMODAL;
    endfunction

    task automatic lookup(input xlen_t pc, input xlen_t inst);
        @(posedge clk);
        if_pc   <= pc;
        if_inst <= inst;
        @(negedge clk);     // outputs settled
    endtask

    // predict and feed the outcome back with the returned history and provider
    task automatic resolve(input xlen_t pc, input xlen_t inst, input xlen_t target,
                           input logic taken, input logic correct);
        ghist_t    h;
        provider_e p;
        lookup(pc, inst);
        h = history;
        p = provider;
        @(posedge clk);
        ex_valid        <= 1'b1;
        ex_taken        <= taken;
        ex_pred_correct <= correct;
        ex_pc           <= pc;
        ex_target       <= target;
        ex_history      <= h;
        ex_provider     <= p;
        @(posedge clk);
        ex_valid <= 1'b0;
        exp_hist = {exp_hist[GHIST_W-2:0], taken};
    endtask

    task automatic compare_history();
        @(negedge clk);
        check_eq("history_o", history, exp_hist);
    endtask

    task automatic reset_defaults();
        lookup(PC_BR, enc_branch(13'h020));
        check_eq("is_cti_o", is_cti, 1);
        check_eq("pred_taken_o", pred_taken, 0);
        check_eq("pred_pc_o", pred_pc, PC_BR + 32'd4);
        check_eq("history_o", history, 0);
        lookup(PC_BR, 32'h0000_0013);   // addi x0, x0, 0
        check_eq("is_cti_o", is_cti, 0);
        check_eq("pred_taken_o", pred_taken, 0);
        check_eq("pred_pc_o", pred_pc, PC_BR + 32'd4);
    endtask

    task automatic jal_target_learning();
        lookup(PC_JAL, enc_jal(21'h800));
        check_eq("pred_taken_o", pred_taken, 1);
        check_eq("pred_pc_o", pred_pc, PC_JAL + 32'h800);
        resolve(PC_JAL, enc_jal(21'h800), 32'h0003_0000, 1'b1, 1'b1);
        lookup(PC_JAL, enc_jal(21'h800));
        check_eq("pred_pc_o", pred_pc, 32'h0003_0000);
    endtask

    task automatic bimodal_learning();
        check_eq("bimodal pc choice", provider_with_reset_tags(PC_BR, exp_hist), PROV_BIMODAL);
        repeat (2) resolve(PC_BR, enc_branch(13'h040), PC_BR + 32'h40, 1'b1, 1'b1);
        check_eq("bimodal pc choice", provider_with_reset_tags(PC_BR, exp_hist), PROV_BIMODAL);
        lookup(PC_BR, enc_branch(13'h040));
        check_eq("provider_o", provider, PROV_BIMODAL);
        check_eq("pred_taken_o", pred_taken, 1);
        check_eq("pred_pc_o", pred_pc, PC_BR + 32'h40);
    endtask

    task automatic history_shifting();
        logic [7:0] pattern;
        pattern = 8'b1011_0010;
        for (int i = 7; i >= 0; i--) begin
            resolve(PC_HIS, enc_branch(13'h010), PC_HIS + 32'h10, pattern[i], 1'b1);
            compare_history();
            @(posedge clk);
            ex_taken <= 1'b1;   // no valid strobe so no shift
            @(posedge clk);
            compare_history();
        end
        // fill with ones so later taken updates keep the history
        repeat (16) resolve(PC_HIS, enc_branch(13'h010), PC_HIS + 32'h10, 1'b1, 1'b1);
        compare_history();
        check_eq("history_o", history, 16'hffff);
    endtask

    task automatic t1_allocation();
        ghist_t h_before;
        lookup(PC_ALC, enc_branch(13'h080));
        h_before = history;
        check_eq("bimodal pc choice", provider_with_reset_tags(PC_ALC, h_before), PROV_BIMODAL);
        check_eq("provider_o", provider, PROV_BIMODAL);
        check_eq("pred_taken_o", pred_taken, 0);
        resolve(PC_ALC, enc_branch(13'h080), PC_ALC + 32'h80, 1'b1, 1'b0);
        lookup(PC_ALC, enc_branch(13'h080));
        check_eq("t1 index", t1_index_calc(PC_ALC, history), t1_index_calc(PC_ALC, h_before));
        check_eq("t1 tag", t1_tag_calc(PC_ALC, history), t1_tag_calc(PC_ALC, h_before));
        check_eq("provider_o", provider, PROV_T1);
        check_eq("pred_taken_o", pred_taken, 1);
        check_eq("pred_pc_o", pred_pc, PC_ALC + 32'h80);
    endtask

    task automatic btb_round_robin();
        resolve(PC_S0, enc_jal(21'h040), PC_S0 + 32'h1000, 1'b1, 1'b1);
        resolve(PC_S1, enc_jal(21'h040), PC_S1 + 32'h1000, 1'b1, 1'b1);
        resolve(PC_S2, enc_jal(21'h040), PC_S2 + 32'h1000, 1'b1, 1'b1);   // evicts S0
        lookup(PC_S0, enc_jal(21'h040));
        check_eq("pred_pc_o", pred_pc, PC_S0 + 32'h40);
        lookup(PC_S1, enc_jal(21'h040));
        check_eq("pred_pc_o", pred_pc, PC_S1 + 32'h1000);
        lookup(PC_S2, enc_jal(21'h040));
        check_eq("pred_pc_o", pred_pc, PC_S2 + 32'h1000);
    endtask

    initial begin
        rst             = 1'b1;
        if_pc           = '0;
        if_inst         = '0;
        ex_valid        = 1'b0;
        ex_taken        = 1'b0;
        ex_pred_correct = 1'b0;
        ex_pc           = '0;
        ex_target       = '0;
        ex_history      = '0;
        ex_provider     = PROV_BIMODAL;
        exp_hist        = '0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        reset_defaults();
        jal_target_learning();
        bimodal_learning();
        history_shifting();
        t1_allocation();
        btb_round_robin();
        if (bpu_top_i.bpu_asserts_i.violations == 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            $display("bound assertions failed %0d times", bpu_top_i.bpu_asserts_i.violations);
            end_in_failure();
        end
    end

endmodule

//--- tests/bpu_asserts.sv
module bpu_asserts (
    input logic                clk,
    input logic                rst,
    input logic                is_cti_i,
    input logic                pred_taken_i,
    input bpu_cfg_pkg::xlen_t  if_pc_i,
    input bpu_cfg_pkg::xlen_t  pred_pc_i,
    input logic                ex_valid_i,
    input bpu_cfg_pkg::ghist_t history_i
);
    import bpu_cfg_pkg::*;

    int violations = 0;    // failed assertion count

    taken_is_cti: assert property (@(posedge clk) disable iff (rst)
        pred_taken_i |-> is_cti_i)
        else begin
            violations++;
            $error("taken prediction on a non control instruction");
        end

    // sequential fetch for everything else
    seq_pc: assert property (@(posedge clk) disable iff (rst)
        !is_cti_i |-> pred_pc_i == xlen_t'(if_pc_i + 32'd4))
        else begin
            violations++;
            $error("next pc is not pc+4 for a plain instruction");
        end

    history_hold: assert property (@(posedge clk) disable iff (rst)
        !ex_valid_i |=> $stable(history_i))
        else begin
            violations++;
            $error("history moved without an update");
        end

endmodule

bind bpu_top bpu_asserts bpu_asserts_i (
    .clk(clk), .rst(rst), .is_cti_i(is_cti_o), .pred_taken_i(pred_taken_o),
    .if_pc_i(if_pc_i), .pred_pc_i(pred_pc_o), .ex_valid_i(ex_valid_i),
    .history_i(history_o)
);

//--- verilog/bpu_top.sv
module bpu_top #(
    parameter int BTB_SETS = bpu_cfg_pkg::BTB_SETS,
    parameter int BTB_WAYS = bpu_cfg_pkg::BTB_WAYS
) (
    input  logic                   clk,
    input  logic                   rst,
    // fetch
    input  bpu_cfg_pkg::xlen_t     if_pc_i,
    input  bpu_cfg_pkg::xlen_t     if_inst_i,
    // execute feedback
    input  logic                   ex_valid_i,
    input  logic                   ex_taken_i,
    input  logic                   ex_pred_correct_i,
    input  bpu_cfg_pkg::xlen_t     ex_pc_i,
    input  bpu_cfg_pkg::xlen_t     ex_target_i,
    input  bpu_cfg_pkg::ghist_t    ex_history_i,
    input  rv_inst_pkg::provider_e ex_provider_i,
    // prediction
    output logic                   is_cti_o,
    output logic                   pred_taken_o,
    output bpu_cfg_pkg::xlen_t     pred_pc_o,
    output rv_inst_pkg::provider_e provider_o,
    output bpu_cfg_pkg::ghist_t    history_o
);
    import bpu_cfg_pkg::*;

    logic  dir_taken;
    logic  btb_hit;
    xlen_t btb_target;

    bpu_update_if upd_bus ();

    assign upd_bus.valid        = ex_valid_i;
    assign upd_bus.taken        = ex_taken_i;
    assign upd_bus.pred_correct = ex_pred_correct_i;
    assign upd_bus.pc           = ex_pc_i;
    assign upd_bus.target       = ex_target_i;
    assign upd_bus.history      = ex_history_i;
    assign upd_bus.provider     = ex_provider_i;

    tage_direction tage_direction_i (
        .clk         (clk),
        .rst         (rst),
        .lookup_pc_i (if_pc_i),
        .upd         (upd_bus.dir_mp),
        .dir_taken_o (dir_taken),
        .provider_o  (provider_o),
        .history_o   (history_o)
    );

    branch_target_buffer #(
        .BTB_SETS (BTB_SETS),
        .BTB_WAYS (BTB_WAYS)
    ) branch_target_buffer_i (
        .clk          (clk),
        .rst          (rst),
        .lookup_pc_i  (if_pc_i),
        .upd          (upd_bus.btb_mp),
        .btb_hit_o    (btb_hit),
        .btb_target_o (btb_target)
    );

    next_pc_select next_pc_select_i (
        .pc_i         (if_pc_i),
        .inst_i       (if_inst_i),
        .dir_taken_i  (dir_taken),
        .btb_hit_i    (btb_hit),
        .btb_target_i (btb_target),
        .is_cti_o     (is_cti_o),
        .pred_taken_o (pred_taken_o),
        .pred_pc_o    (pred_pc_o)
    );

endmodule

//--- verilog/next_pc_select.sv
module next_pc_select (
    input  bpu_cfg_pkg::xlen_t pc_i,
    input  bpu_cfg_pkg::xlen_t inst_i,
    input  logic               dir_taken_i,
    input  logic               btb_hit_i,
    input  bpu_cfg_pkg::xlen_t btb_target_i,
    output logic               is_cti_o,
    output logic               pred_taken_o,
    output bpu_cfg_pkg::xlen_t pred_pc_o
);
    import bpu_cfg_pkg::*;
    import rv_inst_pkg::*;

    opcode_t opcode;
    xlen_t   imm_b, imm_j;
    xlen_t   pc_seq;

    assign opcode = inst_i[6:0];
    assign pc_seq = pc_i + 32'd4;

    // sign extended immediates, bit 0 always zero
    assign imm_b = {{(XLEN-12){inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    assign imm_j = {{(XLEN-20){inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

    always_comb begin
        is_cti_o     = 1'b0;
        pred_taken_o = 1'b0;
        pred_pc_o    = pc_seq;
        case (opcode)
            OPC_JAL: begin
                is_cti_o     = 1'b1;
                pred_taken_o = 1'b1;    // unconditional
                pred_pc_o    = btb_hit_i ? btb_target_i : pc_i + imm_j;
            end
            OPC_BRANCH: begin
                is_cti_o = 1'b1;
                if (dir_taken_i) begin
                    pred_taken_o = 1'b1;
                    pred_pc_o    = btb_hit_i ? btb_target_i : pc_i + imm_b;
                end
            end
            OPC_JALR: begin
                // target unknown without the BTB
                is_cti_o = 1'b1;
                if (dir_taken_i && btb_hit_i) begin
                    pred_taken_o = 1'b1;
                    pred_pc_o    = btb_target_i;
                end
            end
            default: ;
        endcase
    end

endmodule

//--- verilog/branch_target_buffer.sv
module branch_target_buffer #(
    parameter int BTB_SETS = 256,
    parameter int BTB_WAYS = 2
) (
    input  logic               clk,
    input  logic               rst,
    input  bpu_cfg_pkg::xlen_t lookup_pc_i,
    bpu_update_if.btb_mp       upd,
    output logic               btb_hit_o,
    output bpu_cfg_pkg::xlen_t btb_target_o
);
    import bpu_cfg_pkg::*;

    localparam int SET_W = $clog2(BTB_SETS);
    localparam int WAY_W = (BTB_WAYS > 1) ? $clog2(BTB_WAYS) : 1;
    localparam logic [WAY_W-1:0] WAY_LAST = WAY_W'(BTB_WAYS - 1);

    xlen_t            way_pc     [BTB_SETS][BTB_WAYS];  // full pc kept as tag
    xlen_t            way_target [BTB_SETS][BTB_WAYS];
    logic             way_valid  [BTB_SETS][BTB_WAYS];
    logic [WAY_W-1:0] victim     [BTB_SETS];            // round-robin pointer per set

    logic [SET_W-1:0] l_set, u_set;
    logic             u_found;
    logic [WAY_W-1:0] u_way;

    assign l_set = lookup_pc_i[SET_W+1:2];
    assign u_set = upd.pc[SET_W+1:2];

    always_comb begin
        btb_hit_o    = 1'b0;
        btb_target_o = '0;
        for (int w = 0; w < BTB_WAYS; w++) begin
            if (way_valid[l_set][w] && way_pc[l_set][w] == lookup_pc_i) begin
                btb_hit_o    = 1'b1;
                btb_target_o = way_target[l_set][w];
            end
        end
    end

    // is the updating pc already present
    always_comb begin
        u_found = 1'b0;
        u_way   = '0;
        for (int w = 0; w < BTB_WAYS; w++) begin
            if (way_valid[u_set][w] && way_pc[u_set][w] == upd.pc) begin
                u_found = 1'b1;
                u_way   = WAY_W'(w);
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int s = 0; s < BTB_SETS; s++) begin
                victim[s] <= '0;
                for (int w = 0; w < BTB_WAYS; w++) begin
                    way_valid[s][w] <= 1'b0;
                end
            end
        end else if (upd.valid && upd.taken && !u_found) begin
            way_valid[u_set][victim[u_set]] <= 1'b1;
            victim[u_set] <= (victim[u_set] == WAY_LAST) ? '0 : victim[u_set] + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (upd.valid && upd.taken) begin
            if (u_found) begin
                way_target[u_set][u_way] <= upd.target;   // refresh only
            end else begin
                way_pc[u_set][victim[u_set]]     <= upd.pc;
                way_target[u_set][victim[u_set]] <= upd.target;
            end
        end
    end

endmodule

//--- verilog/tage_direction.sv
module tage_direction (
    input  logic                   clk,
    input  logic                   rst,
    input  bpu_cfg_pkg::xlen_t     lookup_pc_i,
    bpu_update_if.dir_mp           upd,
    output logic                   dir_taken_o,
    output rv_inst_pkg::provider_e provider_o,
    output bpu_cfg_pkg::ghist_t    history_o
);
    import bpu_cfg_pkg::*;
    import rv_inst_pkg::*;

    ghist_t    ghist;                       // newest outcome at bit 0
    ctr2_t     bim_ctr [BIMODAL_ENTRIES];
    ctr2_t     t0_ctr  [TAGE_ENTRIES];
    ctr2_t     t1_ctr  [TAGE_ENTRIES];
    tage_tag_t t0_tag  [TAGE_ENTRIES];
    tage_tag_t t1_tag  [TAGE_ENTRIES];

    bm_idx_t   l_bm_idx, u_bm_idx;
    tage_idx_t l_t0_idx, l_t1_idx, u_t0_idx, u_t1_idx;
    tage_tag_t l_t0_tag, l_t1_tag, u_t0_tag, u_t1_tag;
    logic      t0_hit, t1_hit;

    // short history folds the low byte, long history the high byte
    function automatic tage_idx_t t0_index(xlen_t pc, ghist_t h);
        return pc[7:0] ^ h[7:0];
    endfunction

    function automatic tage_idx_t t1_index(xlen_t pc, ghist_t h);
        return pc[7:0] ^ h[15:8];
    endfunction

    function automatic tage_tag_t t0_tag_of(xlen_t pc, ghist_t h);
        return pc[17:8] ^ h[15:6];
    endfunction

    function automatic tage_tag_t t1_tag_of(xlen_t pc, ghist_t h);
        return pc[17:8] ^ {{(TAG_W-8){1'b0}}, h[7:0]};
    endfunction

    function automatic logic partial_eq(tage_tag_t a, tage_tag_t b);
        return a[TAG_W-1 -: PARTIAL_TAG_BITS] == b[TAG_W-1 -: PARTIAL_TAG_BITS];
    endfunction

    function automatic ctr2_t ctr_step(ctr2_t c, logic up);
        if (up) begin
            return (c == 2'd3) ? c : c + 2'd1;
        end else begin
            return (c == 2'd0) ? c : c - 2'd1;
        end
    endfunction

    // lookup side, current history
    assign l_bm_idx = lookup_pc_i[9:1];
    assign l_t0_idx = t0_index(lookup_pc_i, ghist);
    assign l_t1_idx = t1_index(lookup_pc_i, ghist);
    assign l_t0_tag = t0_tag_of(lookup_pc_i, ghist);
    assign l_t1_tag = t1_tag_of(lookup_pc_i, ghist);
    assign t0_hit   = partial_eq(t0_tag[l_t0_idx], l_t0_tag);
    assign t1_hit   = partial_eq(t1_tag[l_t1_idx], l_t1_tag);

    // update side, history returned with the feedback
    assign u_bm_idx = upd.pc[9:1];
    assign u_t0_idx = t0_index(upd.pc, upd.history);
    assign u_t1_idx = t1_index(upd.pc, upd.history);
    assign u_t0_tag = t0_tag_of(upd.pc, upd.history);
    assign u_t1_tag = t1_tag_of(upd.pc, upd.history);

    // longest matching history wins
    always_comb begin
        if (t1_hit) begin
            provider_o  = PROV_T1;
            dir_taken_o = t1_ctr[l_t1_idx][1];
        end else if (t0_hit) begin
            provider_o  = PROV_T0;
            dir_taken_o = t0_ctr[l_t0_idx][1];
        end else begin
            provider_o  = PROV_BIMODAL;
            dir_taken_o = bim_ctr[l_bm_idx][1];
        end
    end

    assign history_o = ghist;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ghist <= '0;
            for (int i = 0; i < BIMODAL_ENTRIES; i++) begin
                bim_ctr[i] <= CTR_WEAK_NT;
            end
            for (int i = 0; i < TAGE_ENTRIES; i++) begin
                t0_ctr[i] <= CTR_WEAK_NT;
                t1_ctr[i] <= CTR_WEAK_NT;
                t0_tag[i] <= '0;
                t1_tag[i] <= '0;
            end
        end else if (upd.valid) begin
            ghist             <= {ghist[GHIST_W-2:0], upd.taken};
            bim_ctr[u_bm_idx] <= ctr_step(bim_ctr[u_bm_idx], upd.taken);
            if (upd.pred_correct) begin
                case (upd.provider)
                    PROV_T1: t1_ctr[u_t1_idx] <= ctr_step(t1_ctr[u_t1_idx], upd.taken);
                    PROV_T0: t0_ctr[u_t0_idx] <= ctr_step(t0_ctr[u_t0_idx], upd.taken);
                    default: ;  // bimodal already stepped
                endcase
            end else begin
                case (upd.provider)
                    // mispredicted tagged entry jumps to strong
                    PROV_T1: t1_ctr[u_t1_idx] <= upd.taken ? 2'd3 : 2'd0;
                    PROV_T0: t0_ctr[u_t0_idx] <= upd.taken ? 2'd3 : 2'd0;
                    default: begin
                        // bimodal missed, try T1 first then T0
                        if (t1_tag[u_t1_idx] != u_t1_tag) begin
                            t1_tag[u_t1_idx] <= u_t1_tag;
                            t1_ctr[u_t1_idx] <= upd.taken ? 2'd2 : 2'd1;  // weak
                        end else if (t0_tag[u_t0_idx] != u_t0_tag) begin
                            t0_tag[u_t0_idx] <= u_t0_tag;
                            t0_ctr[u_t0_idx] <= upd.taken ? 2'd2 : 2'd1;
                        end
                    end
                endcase
            end
        end
    end

endmodule

//--- verilog/bpu_update_if.sv
interface bpu_update_if;
    import bpu_cfg_pkg::*;
    import rv_inst_pkg::*;

    logic      valid;         // one update per cycle with valid high
    logic      taken;
    logic      pred_correct;
    xlen_t     pc;
    xlen_t     target;
    ghist_t    history;       // history seen at prediction time
    provider_e provider;

    // direction side
    modport dir_mp (
        input valid, taken, pred_correct, pc, history, provider
    );

    // target side, only taken branches matter
    modport btb_mp (
        input valid, taken, pc, target
    );

endinterface

//--- verilog/rv_inst_pkg.sv
package rv_inst_pkg;

    typedef logic [6:0] opcode_t;

    // control transfer opcodes, inst[6:0]
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;

    // which direction table gave the prediction
    // travels down the pipe and comes back with the feedback
    typedef enum logic [1:0] {
        PROV_BIMODAL = 2'd0,
        PROV_T0      = 2'd1,
        PROV_T1      = 2'd2
    } provider_e;

endpackage

//--- verilog/bpu_cfg_pkg.sv
package bpu_cfg_pkg;

    localparam int XLEN    = 32;
    localparam int GHIST_W = 16;

    // direction tables
    localparam int BIMODAL_ENTRIES  = 512;  // pc[9:1]
    localparam int TAGE_ENTRIES     = 256;  // pc[7:0] hashed with history
    localparam int TAG_W            = 10;
    localparam int PARTIAL_TAG_BITS = 6;    // upper tag bits that take part in a match

    // target buffer defaults, the top level may override
    localparam int BTB_SETS = 256;
    localparam int BTB_WAYS = 2;

    typedef logic [XLEN-1:0]    xlen_t;     // address or instruction word
    typedef logic [GHIST_W-1:0] ghist_t;
    typedef logic [1:0]         ctr2_t;     // saturating counter
    typedef logic [TAG_W-1:0]   tage_tag_t;

    typedef logic [$clog2(BIMODAL_ENTRIES)-1:0] bm_idx_t;
    typedef logic [$clog2(TAGE_ENTRIES)-1:0]    tage_idx_t;

    // weakly not taken
    localparam ctr2_t CTR_WEAK_NT = 2'd1;

endpackage
